//--- logic/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // Datapath widths
    localparam int PIX_W     = 16;
    localparam int COEF_W    = 16;
    localparam int ACC_W     = 48;
    localparam int FRAC_BITS = 8;     // Bias is aligned to the product fraction
    localparam int NTAPS     = 9;

    // Partial-sum buffer
    localparam int PSUM_DEPTH = 256;
    localparam int PSUM_AW    = 8;

    // APB register map, byte offsets
    localparam logic [11:0] REG_CTRL      = 12'h000;
    localparam logic [11:0] REG_BIAS      = 12'h004;
    localparam logic [11:0] REG_RD_ADDR   = 12'h008;
    localparam logic [11:0] REG_RESULT_LO = 12'h00C;
    localparam logic [11:0] REG_RESULT_HI = 12'h010;
    localparam logic [11:0] REG_COEF_BASE = 12'h020;  // Nine words up to 0x40

    // 3x3 pixel window, row order
    typedef struct packed {
        logic signed [PIX_W-1:0] p00, p01, p02;
        logic signed [PIX_W-1:0] p10, p11, p12;
        logic signed [PIX_W-1:0] p20, p21, p22;
    } window_t;

    // Kernel coefficients, same order as the window
    typedef struct packed {
        logic signed [COEF_W-1:0] k00, k01, k02;
        logic signed [COEF_W-1:0] k10, k11, k12;
        logic signed [COEF_W-1:0] k20, k21, k22;
    } kernel_t;

    typedef struct packed {
        logic               valid;
        logic               add_bias;  // First input-channel pass
        logic [PSUM_AW-1:0] addr;
        window_t            win;
    } pe_stream_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- logic/mac3x3.sv
`timescale 1ns/10ps
`default_nettype none

module mac3x3 import conv_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  window_t                 win,
    input  kernel_t                 kern,
    output logic signed [ACC_W-1:0] sum
);

    logic [NTAPS*PIX_W-1:0]  win_flat;
    logic [NTAPS*COEF_W-1:0] kern_flat;

    logic signed [PIX_W-1:0]  px   [NTAPS];
    logic signed [COEF_W-1:0] kx   [NTAPS];
    logic signed [ACC_W-1:0]  prod [NTAPS];
    logic signed [ACC_W-1:0]  lvl1 [4];
    logic signed [ACC_W-1:0]  lvl2 [2];
    logic signed [ACC_W-1:0]  tree_sum;

    assign win_flat  = win;
    assign kern_flat = kern;

    // p00 and k00 sit in the top slice
    for (genvar i = 0; i < NTAPS; i++) begin : g_tap
        assign px[i]   = win_flat[(NTAPS-1-i)*PIX_W +: PIX_W];
        assign kx[i]   = kern_flat[(NTAPS-1-i)*COEF_W +: COEF_W];
        assign prod[i] = px[i] * kx[i];  // Operands extend to ACC_W first
    end

    for (genvar j = 0; j < 4; j++) begin : g_lvl1
        assign lvl1[j] = prod[2*j] + prod[2*j+1];
    end

    for (genvar k = 0; k < 2; k++) begin : g_lvl2
        assign lvl2[k] = lvl1[2*k] + lvl1[2*k+1];
    end

    // Odd tap joins at the last level
    assign tree_sum = lvl2[0] + lvl2[1] + prod[NTAPS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            sum <= '0;
        end else begin
            sum <= tree_sum;
        end
    end

endmodule

`default_nettype wire

//--- logic/psum_bram.sv
`timescale 1ns/10ps
`default_nettype none

module psum_bram import conv_pkg::*; (
    input  logic                    clk,
    input  logic                    we,
    input  logic [PSUM_AW-1:0]      waddr,
    input  logic signed [ACC_W-1:0] wdata,
    input  logic [PSUM_AW-1:0]      raddr,
    output logic signed [ACC_W-1:0] rdata
);

    logic signed [ACC_W-1:0] mem [PSUM_DEPTH];

    // Port A, write only
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Port B, read only
    // A read on the write edge returns the old word
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- logic/pe_datapath.sv
`timescale 1ns/10ps
`default_nettype none

module pe_datapath import conv_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  pe_stream_t              strm,
    input  logic                    kernel_load,
    input  kernel_t                 kernel_in,
    input  logic signed [31:0]      bias,
    output logic [PSUM_AW-1:0]      psum_raddr,
    input  logic signed [ACC_W-1:0] psum_rdata,
    output logic                    psum_we,
    output logic [PSUM_AW-1:0]      psum_waddr,
    output logic signed [ACC_W-1:0] psum_wdata
);

    kernel_t                 kern_q;
    logic signed [ACC_W-1:0] mac_sum;
    logic signed [ACC_W-1:0] bias_ext;
    logic signed [ACC_W-1:0] start_val;

    logic               v1, v2;
    logic               ab1;
    logic [PSUM_AW-1:0] addr1, addr2;

    logic [1:0]         hist_vld;
    logic [PSUM_AW-1:0] hist_addr [2];

    // Active kernel, swapped only on commit
    always_ff @(posedge clk) begin
        if (rst) begin
            kern_q <= '0;
        end else if (kernel_load) begin
            kern_q <= kernel_in;
        end
    end

    mac3x3 u_mac (
        .clk  (clk),
        .rst  (rst),
        .win  (strm.win),
        .kern (kern_q),
        .sum  (mac_sum)
    );

    assign psum_raddr = strm.addr;  // Read at cycle t, data at t+1

    assign bias_ext  = bias;
    assign start_val = ab1 ? (bias_ext <<< FRAC_BITS) : psum_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
        end else begin
            v1 <= strm.valid;
            v2 <= v1;
        end
    end

    always_ff @(posedge clk) begin
        ab1        <= strm.add_bias;
        addr1      <= strm.addr;
        addr2      <= addr1;
        psum_wdata <= mac_sum + start_val;  // Accumulator, valid at t+2
    end

    assign psum_we    = v2;
    assign psum_waddr = addr2;

    // Last two window addresses, for the hazard check
    always_ff @(posedge clk) begin
        if (rst) begin
            hist_vld <= '0;
        end else if (strm.valid) begin
            hist_vld <= {hist_vld[0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (strm.valid) begin
            hist_addr[1] <= hist_addr[0];
            hist_addr[0] <= strm.addr;
        end
    end

    a_we_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(psum_we))
        else $error("psum write enable unknown");

    // Reuse before write-back would read a stale partial sum
    a_no_addr_reuse: assert property (@(posedge clk) disable iff (rst)
        strm.valid |-> !(hist_vld[0] && strm.addr == hist_addr[0])
                    && !(hist_vld[1] && strm.addr == hist_addr[1]))
        else $error("window reuses in-flight address %0d", strm.addr);

endmodule

`default_nettype wire

//--- logic/pe_apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module pe_apb_regs import conv_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  apb_req_t                apb_req,
    output apb_rsp_t                apb_rsp,
    output kernel_t                 kernel_out,
    output logic                    kernel_load,
    output logic signed [31:0]      bias,
    output logic                    rd_req,
    output logic [PSUM_AW-1:0]      rd_addr,
    input  logic                    rd_gnt,
    input  logic signed [ACC_W-1:0] rd_data
);

    logic                    access;
    logic                    wr_en;
    logic                    sel_ctrl, sel_bias, sel_rd_addr, sel_lo, sel_hi, sel_coef;
    logic                    mapped;
    logic                    rd_lo;
    logic                    rd_pend;
    logic [11:0]             coef_off;
    logic [3:0]              coef_idx;
    logic [COEF_W-1:0]       coef_rd;
    logic [COEF_W-1:0]       coef_q [NTAPS];
    logic [NTAPS*COEF_W-1:0] kern_flat;
    logic signed [ACC_W-1:0] result_q;
    logic [31:0]             prdata;

    assign access = apb_req.psel && apb_req.penable;
    assign wr_en  = access && apb_req.pwrite;

    assign sel_ctrl    = apb_req.paddr == REG_CTRL;
    assign sel_bias    = apb_req.paddr == REG_BIAS;
    assign sel_rd_addr = apb_req.paddr == REG_RD_ADDR;
    assign sel_lo      = apb_req.paddr == REG_RESULT_LO;
    assign sel_hi      = apb_req.paddr == REG_RESULT_HI;

    // Word-aligned offsets 0x20..0x40
    assign coef_off = apb_req.paddr - REG_COEF_BASE;
    assign sel_coef = coef_off[1:0] == 2'b00 && coef_off[11:2] < NTAPS;
    assign coef_idx = coef_off[5:2];

    assign mapped = sel_ctrl || sel_bias || sel_rd_addr || sel_lo || sel_hi || sel_coef;

    always_ff @(posedge clk) begin
        if (rst) begin
            bias        <= '0;
            rd_addr     <= '0;
            kernel_load <= 1'b0;
            for (int i = 0; i < NTAPS; i++) begin
                coef_q[i] <= '0;
            end
        end else begin
            kernel_load <= wr_en && sel_ctrl && apb_req.pwdata[0];  // One-cycle pulse
            if (wr_en && sel_bias) begin
                bias <= apb_req.pwdata;
            end
            if (wr_en && sel_rd_addr) begin
                rd_addr <= apb_req.pwdata[PSUM_AW-1:0];
            end
            if (wr_en && sel_coef) begin
                coef_q[coef_idx] <= apb_req.pwdata[COEF_W-1:0];
            end
        end
    end

    for (genvar i = 0; i < NTAPS; i++) begin : g_kern
        assign kern_flat[(NTAPS-1-i)*COEF_W +: COEF_W] = coef_q[i];
    end

    assign kernel_out = kern_flat;  // Staged taps with k00 in the top slice

    // Result read waits for port B
    assign rd_lo  = access && !apb_req.pwrite && sel_lo;
    assign rd_req = rd_lo && !rd_pend;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= rd_req && rd_gnt;  // Data arrives next cycle
        end
    end

    // Capture the full word so the high half matches
    always_ff @(posedge clk) begin
        if (rd_pend) begin
            result_q <= rd_data;
        end
    end

    assign coef_rd = coef_q[coef_idx];

    always_comb begin
        prdata = '0;
        if (sel_bias) begin
            prdata = bias;
        end else if (sel_rd_addr) begin
            prdata = {{(32-PSUM_AW){1'b0}}, rd_addr};
        end else if (sel_lo) begin
            prdata = rd_data[31:0];
        end else if (sel_hi) begin
            prdata = {{(64-ACC_W){result_q[ACC_W-1]}}, result_q[ACC_W-1:32]};
        end else if (sel_coef) begin
            prdata = {{(32-COEF_W){coef_rd[COEF_W-1]}}, coef_rd};
        end
    end

    assign apb_rsp.pready  = access && !(rd_lo && !rd_pend);
    assign apb_rsp.pslverr = access && !mapped;
    assign apb_rsp.prdata  = prdata;

    // A granted result read completes on the next cycle
    a_gnt_completes: assert property (@(posedge clk) disable iff (rst)
        rd_req && rd_gnt |=> apb_rsp.pready)
        else $error("granted result read did not complete");

endmodule

`default_nettype wire

//--- logic/conv_pe_top.sv
`timescale 1ns/10ps
`default_nettype none

module conv_pe_top import conv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    input  pe_stream_t strm
);

    kernel_t                 kernel;
    logic                    kernel_load;
    logic signed [31:0]      bias;
    logic                    rd_req;
    logic                    rd_gnt;
    logic [PSUM_AW-1:0]      rd_addr;
    logic [PSUM_AW-1:0]      dp_raddr;
    logic [PSUM_AW-1:0]      bram_raddr;
    logic signed [ACC_W-1:0] psum_rdata;
    logic                    psum_we;
    logic [PSUM_AW-1:0]      psum_waddr;
    logic signed [ACC_W-1:0] psum_wdata;

    // Stream owns port B whenever a window is present
    assign rd_gnt     = rd_req && !strm.valid;
    assign bram_raddr = rd_gnt ? rd_addr : dp_raddr;

    pe_apb_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .kernel_out  (kernel),
        .kernel_load (kernel_load),
        .bias        (bias),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_gnt      (rd_gnt),
        .rd_data     (psum_rdata)
    );

    pe_datapath u_datapath (
        .clk         (clk),
        .rst         (rst),
        .strm        (strm),
        .kernel_load (kernel_load),
        .kernel_in   (kernel),
        .bias        (bias),
        .psum_raddr  (dp_raddr),
        .psum_rdata  (psum_rdata),
        .psum_we     (psum_we),
        .psum_waddr  (psum_waddr),
        .psum_wdata  (psum_wdata)
    );

    psum_bram u_psum (
        .clk   (clk),
        .we    (psum_we),
        .waddr (psum_waddr),
        .wdata (psum_wdata),
        .raddr (bram_raddr),
        .rdata (psum_rdata)
    );

endmodule

`default_nettype wire

//--- tb/pe_tests.svh
task automatic regs_after_reset();
    logic [31:0] rd;
    logic [31:0] wr;
    apb_read(REG_BIAS, rd);
    check("reset bias", 32'h0, rd);
    for (int i = 0; i < NTAPS; i++) begin
        apb_read(coef_addr(i), rd);
        check($sformatf("reset coef %0d", i), 32'h0, rd);
    end
    // Only the low 16 bits are kept and read back sign-extended
    for (int i = 0; i < NTAPS; i++) begin
        wr = next_rand();
        apb_write(coef_addr(i), wr);
        apb_read(coef_addr(i), rd);
        check($sformatf("coef %0d readback", i), {{16{wr[15]}}, wr[15:0]}, rd);
    end
    wr = next_rand();
    set_bias(wr);
    apb_read(REG_BIAS, rd);
    check("bias readback", wr, rd);
endtask

task automatic bias_window();
    kernel_t k;
    window_t w;
    k = {16'sd1, 16'sd2, 16'sd3, -16'sd1, 16'sd5, 16'sd4, 16'sd2, -16'sd3, 16'sd1};
    w = {16'sd10, -16'sd20, 16'sd30, 16'sd7, -16'sd8, 16'sd9, 16'sd100, -16'sd50, 16'sd25};
    stage_kernel(k);
    commit_kernel();
    set_bias(32'sd1234);
    send_window(8'd5, 1'b1, w);
    stream_idle(4);  // Write lands three edges after the window
    check_result("bias window", 8'd5);

    // Large negative pixels and a negative bias
    set_bias(-32'sd70000);
    w = {-16'sd30000, 16'sd1200, -16'sd32768, 16'sd45, -16'sd999, 16'sd0,
         -16'sd17000, 16'sd3, -16'sd25000};
    send_window(8'd6, 1'b1, w);
    stream_idle(4);
    check_result("negative window", 8'd6);
endtask

task automatic accumulate_passes();
    for (int pass = 0; pass < 3; pass++) begin
        stage_kernel(rand_taps());
        commit_kernel();
        if (pass == 0) begin
            set_bias(next_rand());
        end
        send_window(8'd10, pass == 0, rand_taps());
        send_window(8'd11, 1'b1, rand_taps());  // Spacers keep 10 out of the pipeline
        send_window(8'd12, 1'b1, rand_taps());
        stream_idle(2);
    end
    stream_idle(4);
    check_result("three-pass sum", 8'd10);
    check_result("spacer window", 8'd12);
endtask

task automatic staged_kernel_hold();
    window_t w;
    w = rand_taps();
    stage_kernel(rand_taps());
    send_window(8'd20, 1'b1, w);  // Still the old kernel
    stream_idle(4);
    check_result("staged kernel ignored", 8'd20);
    commit_kernel();
    send_window(8'd21, 1'b1, w);
    stream_idle(4);
    check_result("committed kernel", 8'd21);
endtask

task automatic random_stream();
    logic [31:0] r;
    logic [31:0] lo;
    logic [31:0] hi;
    longint      held;
    stage_kernel(rand_taps());
    commit_kernel();
    set_bias(next_rand());
    for (int i = 0; i < 24; i++) begin
        send_window(8'(64 + i), 1'b1, rand_taps());
    end
    stream_idle(2);
    stage_kernel(rand_taps());
    commit_kernel();
    held = psum_model[5];
    fork
        begin
            for (int i = 0; i < 24; i++) begin
                r = next_rand();
                send_window(8'(64 + i), r[0], rand_taps());
            end
            stream_idle(4);
        end
        begin
            // Result read is held off until the stream goes idle
            apb_write(REG_RD_ADDR, 32'd5);
            apb_read(REG_RESULT_LO, lo);
            check("read waits for stream", 64'd0, 64'(stream_busy));
            apb_read(REG_RESULT_HI, hi);
            check("read during stream", held, {hi, lo});
        end
    join
    for (int i = 0; i < 24; i++) begin
        check_result($sformatf("stream addr %0d", 64 + i), 8'(64 + i));
    end
endtask

task automatic unmapped_access();
    logic [31:0] rd;
    logic [31:0] exp32;
    apb_write(12'h044, 32'hffff_ffff);
    check("unmapped write error", 64'd1, 64'(last_err));
    apb_write(12'h022, 32'h1234_5678);  // Misaligned coefficient offset
    check("misaligned write error", 64'd1, 64'(last_err));
    apb_read(12'h014, rd);
    check("unmapped read error", 64'd1, 64'(last_err));
    apb_read(REG_BIAS, rd);
    exp32 = bias_model;
    check("bias after unmapped", exp32, rd);
    check("mapped read no error", 64'd0, 64'(last_err));
    apb_read(coef_addr(0), rd);
    exp32 = tap(stage_model, 0);
    check("coef after unmapped", exp32, rd);
endtask

//--- tb/tb_conv_pe.sv
`timescale 1ns/10ps
`default_nettype none

module tb_conv_pe import conv_pkg::*; ();

    localparam real CLK_PERIOD = 8.0;
    localparam int  RST_CYCLES = 8;
    localparam int  WAIT_LIMIT = 200;  // Cycles an APB transfer may stall
    // APB transfers and windows in each test
    localparam int  N_OPS = 30 + 25 + 50 + 20 + 150 + 10;

    logic       clk;
    logic       rst;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    pe_stream_t strm;

    logic [31:0]        rng_state;
    logic               last_err;     // pslverr of the last transfer
    logic               stream_busy;
    kernel_t            stage_model;  // Coefficients written but not yet committed
    kernel_t            kern_model;   // Kernel the datapath uses
    logic signed [31:0] bias_model;
    longint             psum_model [PSUM_DEPTH];

    conv_pe_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .strm    (strm)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    initial begin
        #(N_OPS * 20 * CLK_PERIOD);
        abort_run("Watchdog expired before all tests finished");
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERROR %s: expected 0x%h, actual 0x%h",
                                name, expected, actual));
        end
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [NTAPS*16-1:0] rand_taps();
        logic [NTAPS*16-1:0] v;
        logic [31:0]         r;
        for (int i = 0; i < NTAPS; i++) begin
            r = next_rand();
            v[i*16 +: 16] = r[15:0];
        end
        return v;
    endfunction

    // Tap 0 is p00 or k00 in the top slice
    function automatic logic signed [15:0] tap(input logic [NTAPS*16-1:0] v, input int i);
        return v[(NTAPS-1-i)*16 +: 16];
    endfunction

    function automatic longint dot9(input window_t w, input kernel_t k);
        longint acc;
        acc = 0;
        for (int i = 0; i < NTAPS; i++) begin
            acc += longint'(tap(w, i)) * longint'(tap(k, i));
        end
        return acc;
    endfunction

    function automatic logic [11:0] coef_addr(input int i);
        return REG_COEF_BASE + 12'(4 * i);
    endfunction

    task automatic apb_xfer(input logic wr, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int waits;
        waits = 0;
        @(negedge clk);
        apb_req.psel    = 1'b1;  // Setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        while (!apb_rsp.pready) begin
            if (waits == WAIT_LIMIT) begin
                abort_run($sformatf("APB transfer at 0x%h never got pready", addr));
            end
            waits++;
            @(negedge clk);
            #1;
        end
        rdata    = apb_rsp.prdata;
        last_err = apb_rsp.pslverr;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        apb_xfer(1'b0, addr, 32'h0, data);
    endtask

    // Updates the expected buffer word as the window goes in
    task automatic send_window(input logic [PSUM_AW-1:0] addr, input logic add_bias,
                               input window_t w);
        longint base;
        base = add_bias ? (longint'(bias_model) <<< FRAC_BITS) : psum_model[addr];
        psum_model[addr] = base + dot9(w, kern_model);
        @(negedge clk);
        strm.valid    = 1'b1;
        strm.add_bias = add_bias;
        strm.addr     = addr;
        strm.win      = w;
        stream_busy   = 1'b1;
    endtask

    task automatic stream_idle(input int cycles);
        @(negedge clk);
        strm.valid  = 1'b0;
        stream_busy = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic stage_kernel(input kernel_t k);
        for (int i = 0; i < NTAPS; i++) begin
            apb_write(coef_addr(i), 32'(tap(k, i)));
        end
        stage_model = k;
    endtask

    task automatic commit_kernel();
        apb_write(REG_CTRL, 32'h1);
        kern_model = stage_model;
    endtask

    task automatic set_bias(input logic signed [31:0] b);
        apb_write(REG_BIAS, b);
        bias_model = b;
    endtask

    task automatic check_result(input string name, input logic [PSUM_AW-1:0] addr);
        logic [31:0] lo;
        logic [31:0] hi;
        apb_write(REG_RD_ADDR, 32'(addr));
        apb_read(REG_RESULT_LO, lo);
        apb_read(REG_RESULT_HI, hi);
        check(name, psum_model[addr], {hi, lo});  // High half is sign-extended
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        apb_req     = '0;
        strm        = '0;
        rng_state   = 32'h7fe4c7cc;
        last_err    = 1'b0;
        stream_busy = 1'b0;
        stage_model = '0;
        kern_model  = '0;
        bias_model  = '0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        regs_after_reset();
        bias_window();
        accumulate_passes();
        staged_kernel_hold();
        random_stream();
        unmapped_access();

        $display("Regression passed");
        $finish;
    end

`include "pe_tests.svh"

endmodule

`default_nettype wire

//--- tb.f
+incdir+tb
logic/conv_pkg.sv
logic/mac3x3.sv
logic/psum_bram.sv
logic/pe_datapath.sv
logic/pe_apb_regs.sv
logic/conv_pe_top.sv
tb/tb_conv_pe.sv

//--- Bender.yml
package:
  name: conv_pe

sources:
  - logic/conv_pkg.sv
  - logic/mac3x3.sv
  - logic/psum_bram.sv
  - logic/pe_datapath.sv
  - logic/pe_apb_regs.sv
  - logic/conv_pe_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_conv_pe.sv
